// ==== verif/nx_agg_column_tests.txt ====
# cfg <far node id hex> <near node id hex> <host ready percent>
# msg <far|near> <message hex> <idle cycles after transfer>; end <far outputs> <near outputs>
cfg 13 25 70
msg near 05800007 2
msg near 75800015 1
msg far  13800001 1
msg near 45800006 0
msg far  93800023 2
msg near 2580003f 0
msg far  13800000 0
msg far  2380000b 0
msg near 37800009 1
msg far  a7800005 0
msg near 63800003 0
msg near 1203a5a5 0
msg far  8a12c0de 0
msg near 2454beef 0
msg far  9b5affee 0
msg near 36c01234 0
msg far  acd13579 0
msg near 0100f00d 0
msg far  b3000042 0
msg near 55471357 0
msg far  c4711111 0
msg near 67e2468a 0
msg far  d5f22222 0
msg near 7309abcd 0
msg far  e8033333 0
msg far  f9444444 0
end 00020020 80000400

// ==== nx_agg_column.f ====
+incdir+common
common/nx_node_pkg.sv
common/nx_msg_pkg.sv
hdl/nx_stream_arbiter.sv
hdl/nx_message_fifo.sv
nx_aggregator/nx_aggregator.sv
hdl/nx_agg_column.sv
verif/nx_tb_clock.sv
verif/nx_agg_column_tb.sv

// ==== run_verilator.sh ====
#!/bin/sh
# Build and run the column aggregation testbench with Verilator.
# Exit status is non-zero when the build fails or the testbench stops with $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f nx_agg_column.f --top-module nx_agg_column_tb -Mdir build_verilator &&
./build_verilator/Vnx_agg_column_tb || {
    echo "simulation failed"
    exit 1
}

// ==== verif/nx_agg_column_tb.sv ====
// ============================================================================
// Data-driven testbench for the column aggregation top level.
// Reads stimulus and final expected vectors from the tests file, drives both
// mesh inbound streams, models signal capture and host ordering, and checks
// every cycle. Host ready is randomized by an xorshift generator.
// ============================================================================

`timescale 1ns/10ps
`include "nx_macros.svh"

module nx_agg_column_tb;

    import nx_node_pkg::*;
    import nx_msg_pkg::*;

    localparam int OUTPUTS = 1 << `NX_INDEX_W;

    logic               clk;
    logic               rst_n;
    node_id_t           far_node_id;
    node_id_t           near_node_id;
    node_message_t      far_data;
    logic               far_valid;
    logic               far_ready;
    node_message_t      near_data;
    logic               near_valid;
    logic               near_ready;
    logic [OUTPUTS-1:0] far_outputs;
    logic [OUTPUTS-1:0] near_outputs;
    node_message_t      host_data;
    logic               host_valid;
    logic               host_ready;
    logic               idle;

    // Stimulus from the tests file
    node_message_t      far_stim[$];
    node_message_t      near_stim[$];
    int                 far_gap[$];
    int                 near_gap[$];
    int                 msg_records;
    int                 ready_pct;
    logic [OUTPUTS-1:0] final_far;
    logic [OUTPUTS-1:0] final_near;
    bit                 end_seen;
    bit                 tests_loaded;

    // Scoreboard state
    logic [OUTPUTS-1:0] model_far;
    logic [OUTPUTS-1:0] model_near;
    node_message_t      far_expect[$];
    node_message_t      near_expect[$];
    bit [15:0]          far_rows;
    bit [15:0]          near_rows;
    bit                 host_stalled;
    node_message_t      stalled_msg;
    logic [31:0]        rnd_state;

    nx_tb_clock #(
        .PERIOD_NS    ( 20 ),
        .RESET_CYCLES ( 3  )
    ) u_clock (
        .o_clk   ( clk   ),
        .o_rst_n ( rst_n )
    );

    nx_agg_column nx_agg_column_i (
        .i_clk                ( clk          ),
        .i_rst_n              ( rst_n        ),
        .i_far_node_id        ( far_node_id  ),
        .i_near_node_id       ( near_node_id ),
        .i_far_inbound_data   ( far_data     ),
        .i_far_inbound_valid  ( far_valid    ),
        .o_far_inbound_ready  ( far_ready    ),
        .i_near_inbound_data  ( near_data    ),
        .i_near_inbound_valid ( near_valid   ),
        .o_near_inbound_ready ( near_ready   ),
        .o_far_outputs        ( far_outputs  ),
        .o_near_outputs       ( near_outputs ),
        .o_host_data          ( host_data    ),
        .o_host_valid         ( host_valid   ),
        .i_host_ready         ( host_ready   ),
        .o_idle               ( idle         )
    );

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_message(input string name, input node_message_t exp,
                                 input node_message_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_outputs(input string name, input logic [OUTPUTS-1:0] exp,
                                 input logic [OUTPUTS-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    // 32 bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Signal addressed to this column in any row
    function automatic bit targets_column(input node_message_t msg, input node_id_t node);
        return (msg.header.command == CMD_SIGNAL) && (msg.header.column == node.column);
    endfunction

    // ========================================================================
    // Tests file
    // ========================================================================

    task automatic parse_record(input string line);
        string       kind;
        string       src;
        logic [31:0] a;
        logic [31:0] b;
        int          num;
        int          got;
        got = $sscanf(line, "%s", kind);
        if (kind == "cfg") begin
            got = $sscanf(line, "%s %h %h %d", kind, a, b, num);
            if (got != 4) begin
                report_problem("Malformed cfg record in tests file");
            end else begin
                far_node_id  = node_id_t'(a[7:0]);
                near_node_id = node_id_t'(b[7:0]);
                ready_pct    = num;
            end
        end else if (kind == "msg") begin
            got = $sscanf(line, "%s %s %h %d", kind, src, a, num);
            if (got != 4 || (src != "far" && src != "near")) begin
                report_problem("Malformed msg record in tests file");
            end else if (src == "far") begin
                far_stim.push_back(node_message_t'(a));
                far_gap.push_back(num);
                msg_records++;
            end else begin
                near_stim.push_back(node_message_t'(a));
                near_gap.push_back(num);
                msg_records++;
            end
        end else if (kind == "end") begin
            got = $sscanf(line, "%s %h %h", kind, a, b);
            final_far  = a;
            final_near = b;
            end_seen   = (got == 3);
        end else begin
            report_problem($sformatf("Unknown record '%s' in tests file", kind));
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    got;
        string line;
        fd = $fopen("verif/nx_agg_column_tests.txt", "r");
        if (fd == 0) begin
            report_problem("Could not open verif/nx_agg_column_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            // Skip comments and blank lines
            if (got > 0 && line.len() > 1 && line[0] != "#") begin
                parse_record(line);
            end
        end
        $fclose(fd);
        if (!end_seen || msg_records == 0) begin
            report_problem("Tests file holds no messages or no end record");
        end
    endtask

    // ========================================================================
    // Mesh drivers
    // ========================================================================

    task automatic present(input bit is_far, input node_message_t msg, input logic valid);
        if (is_far) begin
            far_data  = msg;
            far_valid = valid;
        end else begin
            near_data  = msg;
            near_valid = valid;
        end
    endtask

    // Hold each message until ready at an edge, then idle for its gap
    task automatic drive_source(input bit is_far);
        node_message_t msg;
        int            gap;
        int            count;
        int            i;
        bit            fired;
        count = is_far ? far_stim.size() : near_stim.size();
        for (i = 0; i < count; i++) begin
            msg = is_far ? far_stim[i] : near_stim[i];
            gap = is_far ? far_gap[i] : near_gap[i];
            present(is_far, msg, 1'b1);
            fired = 1'b0;
            while (!fired) begin
                // Ready is settled mid-cycle and holds to the edge
                @(negedge clk);
                fired = is_far ? far_ready : near_ready;
                @(posedge clk);
            end
            #1;
            present(is_far, msg, 1'b0);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // ========================================================================
    // Scoreboard sampled mid-cycle
    // ========================================================================

    task automatic capture_inbound(input bit is_far, input node_message_t msg);
        if (is_far && targets_column(msg, far_node_id)) begin
            model_far[msg.index] = msg.state;
        end else if (is_far) begin
            far_expect.push_back(msg);
            far_rows[msg.header.row] = 1'b1;
        end else if (targets_column(msg, near_node_id)) begin
            model_near[msg.index] = msg.state;
        end else begin
            near_expect.push_back(msg);
            near_rows[msg.header.row] = 1'b1;
        end
    endtask

    // Source told apart by header row
    task automatic retire_host(input node_message_t msg);
        bit from_far;
        bit from_near;
        from_far  = far_rows[msg.header.row];
        from_near = near_rows[msg.header.row];
        if (from_far == from_near) begin
            report_problem($sformatf("Host message %h matches no single source", msg));
        end else if (from_far && far_expect.size() == 0) begin
            report_problem($sformatf("Host message %h was never sent by far", msg));
        end else if (from_near && near_expect.size() == 0) begin
            report_problem($sformatf("Host message %h was never sent by near", msg));
        end else if (from_far) begin
            check_message("o_host_data", far_expect.pop_front(), msg);
        end else begin
            check_message("o_host_data", near_expect.pop_front(), msg);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && tests_loaded) begin
            // Outputs reflect every capture up to the last edge
            check_outputs("o_far_outputs", model_far, far_outputs);
            check_outputs("o_near_outputs", model_near, near_outputs);
            // Queued messages are still held somewhere in the column
            if (idle && (far_expect.size() != 0 || near_expect.size() != 0)) begin
                report_problem("o_idle went high while messages were still in flight");
            end
            if (host_stalled && !host_valid) begin
                report_problem("o_host_valid dropped while the host stalled it");
            end else if (host_stalled) begin
                check_message("o_host_data", stalled_msg, host_data);
            end
            host_stalled = host_valid && !host_ready;
            stalled_msg  = host_data;
            // Transfers at the coming edge
            if (far_valid && far_ready) capture_inbound(1'b1, far_data);
            if (near_valid && near_ready) capture_inbound(1'b0, near_data);
            if (host_valid && host_ready) retire_host(host_data);
        end
    end

    // ========================================================================
    // Host back-pressure and watchdog
    // ========================================================================

    initial begin
        host_ready = 1'b0;
        rnd_state  = 32'd5408;
        wait (tests_loaded && rst_n);
        forever begin
            @(posedge clk);
            #1;
            rnd_state  = xorshift32(rnd_state);
            host_ready = (rnd_state % 32'd100) < 32'(ready_pct);
        end
    end

    initial begin
        wait (tests_loaded);
        repeat (msg_records * 40 + 200) @(posedge clk);
        $display("Timeout, %0d far and %0d near messages never reached the host",
                 far_expect.size(), near_expect.size());
        stop_run();
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        far_node_id  = '0;
        near_node_id = '0;
        far_data     = '0;
        far_valid    = 1'b0;
        near_data    = '0;
        near_valid   = 1'b0;
        model_far    = '0;
        model_near   = '0;
        far_rows     = '0;
        near_rows    = '0;
        host_stalled = 1'b0;
        msg_records  = 0;
        ready_pct    = 100;
        end_seen     = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        wait (rst_n);
        @(posedge clk);
        #1;
        // Both sources in parallel
        fork
            drive_source(1'b1);
            drive_source(1'b0);
        join
        // Wait for the column to drain
        do begin
            @(negedge clk);
            #2;
        end while (!(idle && far_expect.size() == 0 && near_expect.size() == 0));
        check_outputs("model far outputs", final_far, model_far);
        check_outputs("model near outputs", final_near, model_near);
        check_outputs("o_far_outputs", final_far, far_outputs);
        check_outputs("o_near_outputs", final_near, near_outputs);
        $display("=== PASS ===");
        $finish;
    end

endmodule : nx_agg_column_tb

// ==== verif/nx_tb_clock.sv ====
// ============================================================================
// Clock and reset source for the column aggregation testbench.
// Free-running clock of PERIOD_NS, reset held low for RESET_CYCLES rising
// edges and released just after an edge.
// ============================================================================

`timescale 1ns/10ps

module nx_tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    // Free-running clock
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Synchronous reset, released off the edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule : nx_tb_clock

// ==== hdl/nx_agg_column.sv ====
// =========================================================================
// Column aggregation top level. The far aggregator forwards its traffic
// into the near aggregator, whose merged stream is buffered by the host
// FIFO. o_idle is high once every stage has drained.
// =========================================================================

`timescale 1ns/10ps
`include "nx_macros.svh"

module nx_agg_column (
      input  logic                            i_clk
    , input  logic                            i_rst_n
    // Node identities
    , input  nx_node_pkg::node_id_t           i_far_node_id
    , input  nx_node_pkg::node_id_t           i_near_node_id
    // Far mesh inbound
    , input  nx_msg_pkg::node_message_t       i_far_inbound_data
    , input  logic                            i_far_inbound_valid
    , output logic                            o_far_inbound_ready
    // Near mesh inbound
    , input  nx_msg_pkg::node_message_t       i_near_inbound_data
    , input  logic                            i_near_inbound_valid
    , output logic                            o_near_inbound_ready
    // Captured output state per aggregator
    , output logic [(1 << `NX_INDEX_W)-1:0]   o_far_outputs
    , output logic [(1 << `NX_INDEX_W)-1:0]   o_near_outputs
    // Host port
    , output nx_msg_pkg::node_message_t       o_host_data
    , output logic                            o_host_valid
    , input  logic                            i_host_ready
    , output logic                            o_idle
);

    import nx_msg_pkg::*;

    localparam int OUTPUTS = 1 << `NX_INDEX_W;

    // Far to near link
    node_message_t far_out_data;
    logic          far_out_valid;
    logic          far_out_ready;

    // Near to FIFO link
    node_message_t near_out_data;
    logic          near_out_valid;
    logic          fifo_wr_ready;

    logic          far_idle;
    logic          near_idle;
    logic          fifo_empty;

    // =====================================================================
    // Aggregator chain
    // =====================================================================

    // End of the chain, passthrough tied idle
    nx_aggregator #(
        .OUTPUTS ( OUTPUTS )
    ) u_far_agg (
          .i_clk               ( i_clk               )
        , .i_rst_n             ( i_rst_n             )
        , .i_node_id           ( i_far_node_id       )
        , .o_idle              ( far_idle            )
        , .o_outputs           ( o_far_outputs       )
        , .i_inbound_data      ( i_far_inbound_data  )
        , .i_inbound_valid     ( i_far_inbound_valid )
        , .o_inbound_ready     ( o_far_inbound_ready )
        , .i_passthrough_data  ( node_message_t'('0) )
        , .i_passthrough_valid ( 1'b0                )
        , .o_passthrough_ready (                     )
        , .o_outbound_data     ( far_out_data        )
        , .o_outbound_valid    ( far_out_valid       )
        , .i_outbound_ready    ( far_out_ready       )
    );

    nx_aggregator #(
        .OUTPUTS ( OUTPUTS )
    ) u_near_agg (
          .i_clk               ( i_clk                )
        , .i_rst_n             ( i_rst_n              )
        , .i_node_id           ( i_near_node_id       )
        , .o_idle              ( near_idle            )
        , .o_outputs           ( o_near_outputs       )
        , .i_inbound_data      ( i_near_inbound_data  )
        , .i_inbound_valid     ( i_near_inbound_valid )
        , .o_inbound_ready     ( o_near_inbound_ready )
        , .i_passthrough_data  ( far_out_data         )
        , .i_passthrough_valid ( far_out_valid        )
        , .o_passthrough_ready ( far_out_ready        )
        , .o_outbound_data     ( near_out_data        )
        , .o_outbound_valid    ( near_out_valid       )
        , .i_outbound_ready    ( fifo_wr_ready        )
    );

    // =====================================================================
    // Host buffering
    // =====================================================================

    nx_message_fifo #(
        .DEPTH ( `NX_FIFO_DEPTH )
    ) u_host_fifo (
          .i_clk      ( i_clk          )
        , .i_rst_n    ( i_rst_n        )
        , .i_wr_data  ( near_out_data  )
        , .i_wr_valid ( near_out_valid )
        , .o_wr_ready ( fifo_wr_ready  )
        , .o_rd_data  ( o_host_data    )
        , .o_rd_valid ( o_host_valid   )
        , .i_rd_ready ( i_host_ready   )
        , .o_empty    ( fifo_empty     )
    );

    // Whole column drained
    assign o_idle = far_idle && near_idle && fifo_empty;

endmodule : nx_agg_column

// ==== nx_aggregator/nx_aggregator.sv ====
// =========================================================================
// Column aggregator. Captures signal messages for its own column into a
// flopped output vector and merges every other inbound message with the
// passthrough stream from the neighbouring aggregator.
// Chain instances by feeding one outbound into the next passthrough.
// =========================================================================

`timescale 1ns/10ps
`include "nx_macros.svh"

module nx_aggregator #(
    parameter int OUTPUTS = 1 << `NX_INDEX_W
) (
      input  logic                      i_clk
    , input  logic                      i_rst_n
    // Identity and status
    , input  nx_node_pkg::node_id_t     i_node_id
    , output logic                      o_idle
    // Captured output state
    , output logic [OUTPUTS-1:0]        o_outputs
    // Inbound from the mesh
    , input  nx_msg_pkg::node_message_t i_inbound_data
    , input  logic                      i_inbound_valid
    , output logic                      o_inbound_ready
    // Passthrough from the neighbouring aggregator
    , input  nx_msg_pkg::node_message_t i_passthrough_data
    , input  logic                      i_passthrough_valid
    , output logic                      o_passthrough_ready
    // Outbound towards the host
    , output nx_msg_pkg::node_message_t o_outbound_data
    , output logic                      o_outbound_valid
    , input  logic                      i_outbound_ready
);

    import nx_msg_pkg::*;

    logic                     is_signal;
    logic [OUTPUTS-1:0]       outputs_q;
    node_message_t [1:0]      comb_data;
    logic [1:0]               comb_valid;
    logic [1:0]               comb_ready;

    // =====================================================================
    // Signal detection
    // =====================================================================

    // Column match only, any row in the column may signal
    assign is_signal = i_inbound_valid
                    && (i_inbound_data.header.command == CMD_SIGNAL)
                    && (i_inbound_data.header.column == i_node_id.column);

    // =====================================================================
    // Output state
    // =====================================================================

    // Indexed bit takes the message state bit
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            outputs_q <= '0;
        end else if (is_signal) begin
            for (int idx = 0; idx < OUTPUTS; idx++) begin
                if (output_index_t'(idx) == i_inbound_data.index) begin
                    outputs_q[idx] <= i_inbound_data.state;
                end
            end
        end
    end

    assign o_outputs = outputs_q;

    // =====================================================================
    // Stream merge
    // =====================================================================

    // Slot 0 gets non-signal mesh traffic
    assign comb_data[0]    = i_inbound_data;
    assign comb_valid[0]   = i_inbound_valid && !is_signal;
    // Signals are consumed here, never stalled
    assign o_inbound_ready = is_signal || comb_ready[0];

    // Slot 1 gets the neighbour
    assign comb_data[1]        = i_passthrough_data;
    assign comb_valid[1]       = i_passthrough_valid;
    assign o_passthrough_ready = comb_ready[1];

    nx_stream_arbiter u_combiner (
          .i_clk       ( i_clk            )
        , .i_rst_n     ( i_rst_n          )
        , .i_data      ( comb_data        )
        , .i_valid     ( comb_valid       )
        , .o_ready     ( comb_ready       )
        , .o_data      ( o_outbound_data  )
        , .o_valid     ( o_outbound_valid )
        , .i_out_ready ( i_outbound_ready )
    );

    // Nothing offered and nothing pending
    assign o_idle = !i_inbound_valid && !i_passthrough_valid && !o_outbound_valid;

    // Mesh source must hold a stalled message
    a_inbound_held : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_inbound_valid && !o_inbound_ready)
            |=> (i_inbound_valid && $stable(i_inbound_data))
    );

endmodule : nx_aggregator

// ==== hdl/nx_message_fifo.sv ====
// =========================================================================
// Synchronous valid/ready FIFO for host-bound messages. A written word
// is visible on the read side on the following cycle; write ready drops
// once DEPTH words are held. Reads and writes may share a cycle.
// =========================================================================

`timescale 1ns/10ps
`include "nx_macros.svh"

module nx_message_fifo #(
    parameter int DEPTH = 4
) (
      input  logic                      i_clk
    , input  logic                      i_rst_n
    // Write side
    , input  nx_msg_pkg::node_message_t i_wr_data
    , input  logic                      i_wr_valid
    , output logic                      o_wr_ready
    // Read side
    , output nx_msg_pkg::node_message_t o_rd_data
    , output logic                      o_rd_valid
    , input  logic                      i_rd_ready
    , output logic                      o_empty
);

    import nx_msg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`NX_MSG_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]     count_q;
    logic                 wr_en;
    logic                 rd_en;

    // Wrap at DEPTH rather than at a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Handshakes
    assign o_wr_ready = (count_q != CNT_W'(DEPTH));
    assign o_rd_valid = (count_q != '0);
    assign o_empty    = (count_q == '0);
    assign wr_en      = i_wr_valid && o_wr_ready;
    assign rd_en      = o_rd_valid && i_rd_ready;

    // Pointers and occupancy
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (rd_en) rd_ptr_q <= ptr_next(rd_ptr_q);
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= i_wr_data;
        end
    end

    // Read side shows the head of queue directly
    assign o_rd_data = node_message_t'(mem_q[rd_ptr_q]);

    // An accepted write never lands on an unread word
    a_no_full_write : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        wr_en |-> ((count_q == '0) || (wr_ptr_q != rd_ptr_q))
    );

    a_count_bound : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        count_q <= CNT_W'(DEPTH)
    );

endmodule : nx_message_fifo

// ==== hdl/nx_stream_arbiter.sv ====
// =========================================================================
// Two input round-robin stream arbiter with a single registered output.
// Inputs and output follow the valid/ready handshake. A winner is loaded
// into the output slot one cycle after it is accepted.
// =========================================================================

`timescale 1ns/10ps
`include "nx_macros.svh"

module nx_stream_arbiter (
      input  logic                            i_clk
    , input  logic                            i_rst_n
    // Competing input streams
    , input  nx_msg_pkg::node_message_t [1:0] i_data
    , input  logic [1:0]                      i_valid
    , output logic [1:0]                      o_ready
    // Registered output slot
    , output nx_msg_pkg::node_message_t       o_data
    , output logic                            o_valid
    , input  logic                            i_out_ready
);

    import nx_msg_pkg::*;

    // =====================================================================
    // Grant selection
    // =====================================================================

    logic                 slot_free;
    logic                 grant_sel;
    logic                 accept;
    logic                 last_q;
    logic                 valid_q;
    logic [`NX_MSG_W-1:0] data_q;

    // Alternate on contention, otherwise take whichever is valid
    always_comb begin
        if (&i_valid) begin
            grant_sel = !last_q;
        end else begin
            grant_sel = i_valid[1];
        end
    end

    // Slot can load when empty or emptying this cycle
    assign slot_free = !valid_q || i_out_ready;
    assign accept    = slot_free && (|i_valid);

    // Ready only towards the granted input
    assign o_ready[0] = slot_free && !grant_sel;
    assign o_ready[1] = slot_free && grant_sel;

    // =====================================================================
    // Output slot
    // =====================================================================

    // Last grant starts at 1 so slot 0 wins first
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b1;
        end else if (accept) begin
            valid_q <= 1'b1;
            last_q  <= grant_sel;
        end else if (i_out_ready) begin
            valid_q <= 1'b0;
        end
    end

    // Held message
    always_ff @(posedge i_clk) begin
        if (accept) begin
            data_q <= i_data[grant_sel];
        end
    end

    assign o_data  = node_message_t'(data_q);
    assign o_valid = valid_q;

    // Stalled output must not change under the consumer
    a_out_stable : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && !i_out_ready) |=> (o_valid && $stable(o_data))
    );

endmodule : nx_stream_arbiter

// ==== common/nx_msg_pkg.sv ====
// =========================================================================
// Message format carried on every mesh and host stream. Streams pass a
// node_message_t alongside a valid and ready pair; only signal messages
// are decoded, all other payloads are opaque to the aggregators.
// =========================================================================

`include "nx_macros.svh"

package nx_msg_pkg;

    // =====================================================================
    // Command encoding
    // =====================================================================

    // Two bit command, order fixes the encoding
    typedef enum logic [1:0] {
        CMD_LOAD,
        CMD_INPUT,
        CMD_SIGNAL,
        CMD_CONTROL
    } node_command_e;

    // =====================================================================
    // Header and body
    // =====================================================================

    // Target node address plus command, 10 bits
    typedef struct packed {
        nx_node_pkg::row_t    row;
        nx_node_pkg::column_t column;
        node_command_e        command;
    } msg_header_t;

    // Position within an aggregator output vector
    typedef logic [`NX_INDEX_W-1:0] output_index_t;

    // Complete message, header at the top
    // Signal messages use only index and state
    // Other commands treat payload, index and state as data
    typedef struct packed {
        msg_header_t   header;
        logic [15:0]   payload;
        output_index_t index;
        logic          state;
    } node_message_t;

endpackage : nx_msg_pkg

// ==== common/nx_node_pkg.sv ====
// =========================================================================
// Mesh node identity types. Aggregators compare incoming message
// addresses against a node_id_t to find messages for their column.
// =========================================================================

`include "nx_macros.svh"

package nx_node_pkg;

    // Row address within the mesh
    typedef logic [`NX_ROW_W-1:0] row_t;

    // Column address within the mesh
    typedef logic [`NX_COL_W-1:0] column_t;

    // Full node identity, row in the upper bits
    typedef struct packed {
        row_t    row;
        column_t column;
    } node_id_t;

endpackage : nx_node_pkg

// ==== common/nx_macros.svh ====
// =========================================================================
// Width and depth definitions for the column aggregation subsystem.
// Include this header in any file that sizes a field, a vector or a FIFO;
// the matching typedefs live in the node and message packages.
// =========================================================================

`ifndef NX_MACROS_SVH
`define NX_MACROS_SVH

// =========================================================================
// Mesh addressing
// =========================================================================

// Row address of a node within the mesh
`define NX_ROW_W 4

// Column address of a node within the mesh
`define NX_COL_W 4

// =========================================================================
// Message layout
// =========================================================================

// Output index carried by signal messages, 5 bits gives 32 outputs
`define NX_INDEX_W 5

// Full packed message width, header plus payload plus index plus state
`define NX_MSG_W 32

// Host-bound buffering depth in messages
`define NX_FIFO_DEPTH 4

`endif
